//--- design/alu_pkg.sv
package alu_pkg;

  localparam int WORD_W      = 64;
  localparam int HALF_W      = 32;
  localparam int ALU_THREADS = 2;
  localparam int PARITY_BITS = 8;   // parity looks at the low byte only

  typedef logic [WORD_W-1:0] word_t;

  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_mov,
    op_zxt8,
    op_zxt16,
    op_sxt8,
    op_sxt16,
    op_sxt32,
    op_cmov,
    op_cset
  } alu_op_t;

  // base conditions that the invert bit doubles to sixteen
  typedef enum logic [2:0] {
    cc_z,
    cc_s,
    cc_ule,
    cc_ult,
    cc_sle,
    cc_slt,
    cc_o,
    cc_p
  } cond_code_t;

  typedef struct packed {
    cond_code_t code;
    logic       invert;
  } cond_t;

  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } flags_t;

  typedef struct packed {
    alu_op_t op;
    logic    is_64;
    cond_t   cond;
    logic    set_flags;
    logic    thread;
    word_t   a;
    word_t   b;
    flags_t  flags_in;
  } alu_req_t;

  typedef struct packed {
    logic use_adder;
    logic subtract;
    logic use_logic;
    logic use_cond;
    logic writes_flags;
    logic is_64;
  } alu_ctrl_t;

  typedef struct packed {
    word_t  result;
    flags_t flags;
    logic   sets_flags;
  } alu_resp_t;

endpackage

//--- design/alu_decode.sv
module alu_decode (
  input  alu_pkg::alu_op_t   op,
  input  logic               is_64,
  input  logic               set_flags,
  output alu_pkg::alu_ctrl_t ctrl
);
  import alu_pkg::*;

  always_comb begin
    ctrl = '0;
    ctrl.is_64 = 1'b1;   // extends and conditionals always give a full word
    case (op)
      op_add: begin
        ctrl.use_adder = 1'b1;
        ctrl.is_64 = is_64;
      end
      op_sub: begin
        ctrl.use_adder = 1'b1;
        ctrl.subtract = 1'b1;
        ctrl.is_64 = is_64;
      end
      op_and,
      op_or,
      op_xor: begin
        ctrl.use_logic = 1'b1;
        ctrl.is_64 = is_64;
      end
      op_mov: begin
        ctrl.is_64 = is_64;
      end
      op_zxt8,
      op_zxt16,
      op_sxt8,
      op_sxt16,
      op_sxt32: begin
        ctrl.is_64 = 1'b1;
      end
      op_cmov,
      op_cset: begin
        ctrl.use_cond = 1'b1;
      end
      default: begin
        ctrl.is_64 = 1'b1;
      end
    endcase
    // moves, extends and conditionals leave flags alone
    ctrl.writes_flags = set_flags & (ctrl.use_adder | ctrl.use_logic);
  end

  // result mux picks at most one path
  a_one_path: assert final ($onehot0({ctrl.use_adder, ctrl.use_logic, ctrl.use_cond}));

endmodule

//--- design/alu_adder.sv
module alu_adder (
  input  alu_pkg::word_t a,
  input  alu_pkg::word_t b,
  input  logic           subtract,
  input  logic           is_64,
  output alu_pkg::word_t sum,
  output logic           c4,
  output logic           c32,
  output logic           c64
);
  import alu_pkg::*;

  word_t             b_inv;
  word_t             a_x;
  word_t             b_x;
  logic [WORD_W:0]   total;

  assign b_inv = subtract ? ~b : b;

  // upper half held quiet on 32-bit ops
  assign a_x = is_64 ? a : {{(WORD_W-HALF_W){1'b0}}, a[HALF_W-1:0]};
  assign b_x = is_64 ? b_inv : {{(WORD_W-HALF_W){1'b0}}, b_inv[HALF_W-1:0]};

  assign total = {1'b0, a_x} + {1'b0, b_x} + {{WORD_W{1'b0}}, subtract};
  assign sum   = total[WORD_W-1:0];

  // carry into bit k recovered from the sum bit
  assign c4  = a_x[4] ^ b_x[4] ^ sum[4];
  assign c32 = a_x[HALF_W] ^ b_x[HALF_W] ^ sum[HALF_W];
  assign c64 = total[WORD_W];

endmodule

//--- design/alu_cond_eval.sv
module alu_cond_eval (
  input  alu_pkg::flags_t flags,
  input  alu_pkg::cond_t  cond,
  output logic            taken
);
  import alu_pkg::*;

  logic base;

  always_comb begin
    case (cond.code)
      cc_z: begin
        base = flags.z;
      end
      cc_s: begin
        base = flags.s;
      end
      cc_ule: begin
        base = flags.c | flags.z;
      end
      cc_ult: begin
        base = flags.c;
      end
      cc_sle: begin
        base = (flags.s ^ flags.o) | flags.z;
      end
      cc_slt: begin
        base = flags.s ^ flags.o;
      end
      cc_o: begin
        base = flags.o;
      end
      default: begin
        base = flags.p;   // cc_p
      end
    endcase
  end

  assign taken = base ^ cond.invert;

endmodule

//--- design/alu_result_mux.sv
module alu_result_mux (
  input  alu_pkg::alu_req_t  req,
  input  alu_pkg::alu_ctrl_t ctrl,
  input  alu_pkg::word_t     sum,
  input  logic               taken,
  output alu_pkg::word_t     result
);
  import alu_pkg::*;

  word_t logic_res;
  word_t move_res;
  word_t cond_res;
  word_t pick;

  always_comb begin
    case (req.op)
      op_and: begin
        logic_res = req.a & req.b;
      end
      op_or: begin
        logic_res = req.a | req.b;
      end
      default: begin
        logic_res = req.a ^ req.b;
      end
    endcase
  end

  // extends and plain mov take their value from b
  always_comb begin
    case (req.op)
      op_zxt8: begin
        move_res = {{(WORD_W-8){1'b0}}, req.b[7:0]};
      end
      op_zxt16: begin
        move_res = {{(WORD_W-16){1'b0}}, req.b[15:0]};
      end
      op_sxt8: begin
        move_res = {{(WORD_W-8){req.b[7]}}, req.b[7:0]};
      end
      op_sxt16: begin
        move_res = {{(WORD_W-16){req.b[15]}}, req.b[15:0]};
      end
      op_sxt32: begin
        move_res = {{(WORD_W-HALF_W){req.b[HALF_W-1]}}, req.b[HALF_W-1:0]};
      end
      default: begin
        move_res = req.b;
      end
    endcase
  end

  assign cond_res = (req.op == op_cset) ? {{(WORD_W-1){1'b0}}, taken}
                                        : (taken ? req.b : req.a);

  always_comb begin
    if (ctrl.use_adder) begin
      pick = sum;
    end else if (ctrl.use_logic) begin
      pick = logic_res;
    end else if (ctrl.use_cond) begin
      pick = cond_res;
    end else begin
      pick = move_res;
    end
  end

  assign result = ctrl.is_64 ? pick : {{(WORD_W-HALF_W){1'b0}}, pick[HALF_W-1:0]};

endmodule

//--- design/alu_retire.sv
module alu_retire (
  input  logic                clk,
  input  logic                rst,
  input  logic                valid,
  input  logic                thread,
  input  logic                except,
  input  logic                except_thread,
  input  alu_pkg::alu_ctrl_t  ctrl,
  input  alu_pkg::word_t      result,
  input  logic [1:0]          a_sign,
  input  logic [1:0]          b_sign,
  input  logic                c4,
  input  logic                c32,
  input  logic                c64,
  output logic                ret_valid,
  output alu_pkg::alu_resp_t  resp
);
  import alu_pkg::*;

  logic [ALU_THREADS-1:0] kill_now;
  logic [ALU_THREADS-1:0] kill_prev;   // except seen one cycle back
  logic                   squash;
  alu_ctrl_t              ctrl_q;
  word_t                  res_q;
  logic [1:0]             a_sign_q;
  logic [1:0]             b_sign_q;
  logic                   c4_q;
  logic                   c32_q;
  logic                   c64_q;
  logic                   res_s;
  logic                   op_a_s;
  logic                   op_b_s;
  logic                   carry;
  logic                   ovf;
  flags_t                 flags;

  always_comb begin
    kill_now = '0;
    kill_now[except_thread] = except;
  end

  assign squash = kill_now[thread] | kill_prev[thread];

  always_ff @(posedge clk) begin
    if (rst) begin
      ret_valid <= 1'b0;
      kill_prev <= '0;
      ctrl_q    <= '0;
      res_q     <= '0;
    end else begin
      ret_valid <= valid & ~squash;
      kill_prev <= kill_now;
      ctrl_q    <= ctrl;
      res_q     <= result;
    end
  end

  always_ff @(posedge clk) begin
    a_sign_q <= a_sign;
    b_sign_q <= b_sign;
    c4_q     <= c4;
    c32_q    <= c32;
    c64_q    <= c64;
  end

  // width picks which sign bits and carry count
  assign res_s  = ctrl_q.is_64 ? res_q[WORD_W-1] : res_q[HALF_W-1];
  assign op_a_s = ctrl_q.is_64 ? a_sign_q[1] : a_sign_q[0];
  assign op_b_s = ctrl_q.is_64 ? b_sign_q[1] : b_sign_q[0];
  assign carry  = ctrl_q.is_64 ? c64_q : c32_q;

  // b sign flips for sub
  assign ovf = ((op_a_s ~^ (op_b_s ^ ctrl_q.subtract)) & (res_s ^ op_a_s));

  always_comb begin
    flags = '0;
    if (ctrl_q.writes_flags) begin
      if (ctrl_q.use_adder) begin
        flags.c = carry ^ ctrl_q.subtract;   // borrow on sub
        flags.o = ovf;
        flags.a = c4_q ^ ctrl_q.subtract;
      end
      flags.s = res_s;
      flags.z = (res_q == '0);   // upper half already zero at 32 bits
      flags.p = ~^res_q[PARITY_BITS-1:0];
    end
  end

  assign resp.result     = res_q;
  assign resp.flags      = flags;
  assign resp.sets_flags = ctrl_q.writes_flags;

  a_quiet_after_rst: assert property (@(posedge clk) rst |=> !ret_valid);
  a_flags_gated: assert property (@(posedge clk) disable iff (rst)
    !resp.sets_flags |-> resp.flags == '0);

endmodule

//--- design/alu_top.sv
module alu_top (
  input  logic               clk,
  input  logic               rst,
  input  logic               valid,
  input  alu_pkg::alu_req_t  req,
  input  logic               except,
  input  logic               except_thread,
  output logic               ret_valid,
  output alu_pkg::alu_resp_t resp
);
  import alu_pkg::*;

  alu_ctrl_t ctrl;
  word_t     sum;
  word_t     result;
  logic      c4;
  logic      c32;
  logic      c64;
  logic      taken;

  alu_decode alu_decode_i (
    .op        (req.op),
    .is_64     (req.is_64),
    .set_flags (req.set_flags),
    .ctrl      (ctrl)
  );

  alu_adder alu_adder_i (
    .a        (req.a),
    .b        (req.b),
    .subtract (ctrl.subtract),
    .is_64    (ctrl.is_64),
    .sum      (sum),
    .c4       (c4),
    .c32      (c32),
    .c64      (c64)
  );

  alu_cond_eval alu_cond_eval_i (
    .flags (req.flags_in),
    .cond  (req.cond),
    .taken (taken)
  );

  alu_result_mux alu_result_mux_i (
    .req    (req),
    .ctrl   (ctrl),
    .sum    (sum),
    .taken  (taken),
    .result (result)
  );

  alu_retire alu_retire_i (
    .clk           (clk),
    .rst           (rst),
    .valid         (valid),
    .thread        (req.thread),
    .except        (except),
    .except_thread (except_thread),
    .ctrl          (ctrl),
    .result        (result),
    .a_sign        ({req.a[WORD_W-1], req.a[HALF_W-1]}),
    .b_sign        ({req.b[WORD_W-1], req.b[HALF_W-1]}),
    .c4            (c4),
    .c32           (c32),
    .c64           (c64),
    .ret_valid     (ret_valid),
    .resp          (resp)
  );

endmodule

//--- bench/alu_clock.sv
module alu_clock (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int PERIOD     = 100;
  localparam int RST_CYCLES = 2;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;   // released on a rising edge
  end

endmodule

//--- bench/alu_tb.sv
module alu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import alu_pkg::*;

  localparam logic [31:0] SEED = 32'h97ccdca7;
  localparam int RAND_N   = 12;
  localparam int COND_REP = 4;
  localparam int SQ_N     = 16;
  localparam int N_OPS    = 4 * (4 + RAND_N) + 6 * RAND_N + 7 * RAND_N
                            + 32 * COND_REP + SQ_N;

  typedef struct packed {
    logic      chk;
    logic      valid;
    alu_resp_t resp;
  } expect_t;

  logic      clk;
  logic      rst;
  logic      valid;
  alu_req_t  req;
  logic      except;
  logic      except_thread;
  logic      ret_valid;
  alu_resp_t resp;
  expect_t   expd;         // lines up with the DUT register stage
  expect_t   pending[$];   // one entry per issued cycle
  logic      prev_ex;
  logic      prev_ext;
  logic      rst_phase;    // next request lands while rst is high
  int        errors;
  int        n_pass;
  int        n_fail;

  alu_clock alu_clock_i (
    .clk (clk),
    .rst (rst)
  );

  alu_top alu_top_i (
    .clk           (clk),
    .rst           (rst),
    .valid         (valid),
    .req           (req),
    .except        (except),
    .except_thread (except_thread),
    .ret_valid     (ret_valid),
    .resp          (resp)
  );

  function automatic logic even_parity(input word_t v);
    int ones;
    ones = 0;
    for (int i = 0; i < PARITY_BITS; i++) begin
      ones += v[i];
    end
    return (ones % 2) == 0;
  endfunction

  function automatic logic cond_ref(input flags_t f, input cond_t c);
    logic t;
    case (c.code)
      cc_z:    t = f.z;
      cc_s:    t = f.s;
      cc_ule:  t = f.c | f.z;
      cc_ult:  t = f.c;
      cc_sle:  t = (f.s ^ f.o) | f.z;
      cc_slt:  t = f.s ^ f.o;
      cc_o:    t = f.o;
      default: t = f.p;
    endcase
    return t ^ c.invert;
  endfunction

  function automatic alu_resp_t expect_resp(input alu_req_t r);
    alu_resp_t   e;
    word_t       ma;
    word_t       mb;
    logic [64:0] wide;
    logic        sub;
    int          msb;
    e = '0;
    msb = r.is_64 ? 63 : 31;
    ma = r.is_64 ? r.a : {32'h0, r.a[31:0]};
    mb = r.is_64 ? r.b : {32'h0, r.b[31:0]};
    sub = (r.op == op_sub);
    case (r.op)
      op_add, op_sub: e.result = sub ? ma - mb : ma + mb;
      op_and:   e.result = ma & mb;
      op_or:    e.result = ma | mb;
      op_xor:   e.result = ma ^ mb;
      op_mov:   e.result = mb;
      op_zxt8:  e.result = {56'h0, r.b[7:0]};
      op_zxt16: e.result = {48'h0, r.b[15:0]};
      op_sxt8:  e.result = {{56{r.b[7]}}, r.b[7:0]};
      op_sxt16: e.result = {{48{r.b[15]}}, r.b[15:0]};
      op_sxt32: e.result = {{32{r.b[31]}}, r.b[31:0]};
      op_cmov:  e.result = cond_ref(r.flags_in, r.cond) ? r.b : r.a;
      default:  e.result = {63'h0, cond_ref(r.flags_in, r.cond)};
    endcase
    if (!r.is_64 && r.op inside {op_add, op_sub, op_and, op_or, op_xor, op_mov}) begin
      e.result[63:32] = '0;
    end
    if (r.set_flags && r.op inside {op_add, op_sub, op_and, op_or, op_xor}) begin
      e.sets_flags = 1'b1;
      e.flags.s = e.result[msb];
      e.flags.z = (e.result == '0);
      e.flags.p = even_parity(e.result);
      if (r.op inside {op_add, op_sub}) begin
        wide = {1'b0, ma} + {1'b0, mb};
        e.flags.c = sub ? (ma < mb) : (r.is_64 ? wide[64] : wide[32]);
        e.flags.a = sub ? (ma[3:0] < mb[3:0]) : (({1'b0, ma[3:0]} + {1'b0, mb[3:0]}) > 5'd15);
        e.flags.o = sub ? (ma[msb] != mb[msb]) && (e.result[msb] != ma[msb])
                        : (ma[msb] == mb[msb]) && (e.result[msb] != ma[msb]);
      end
    end
    return e;
  endfunction

  function automatic word_t rand_word();
    return {$urandom, $urandom};
  endfunction

  function automatic alu_req_t build_req(input alu_op_t op, input logic w64, input word_t a,
                                         input word_t b);
    alu_req_t r;
    r = '0;
    r.op = op;
    r.is_64 = w64;
    r.a = a;
    r.b = b;
    r.set_flags = 1'b1;
    return r;
  endfunction

  // drives one clock of stimulus and moves the previous expectation into expd
  task automatic issue(input logic v, input alu_req_t r, input logic ex, input logic ex_t);
    expect_t e;
    @(posedge clk);
    expd <= pending.pop_front();
    valid <= v;
    req <= r;
    except <= ex;
    except_thread <= ex_t;
    e.chk = 1'b1;
    e.valid = v && !rst_phase && !(ex && ex_t == r.thread)
              && !(prev_ex && prev_ext == r.thread);
    e.resp = expect_resp(r);
    pending.push_back(e);
    prev_ex = ex;
    prev_ext = ex_t;
  endtask

  task automatic finish_test(input string name, input int base);
    issue(1'b0, '0, 1'b0, 1'b0);
    issue(1'b0, '0, 1'b0, 1'b0);
    #1;   // let the last check settle
    if (errors == base) begin
      n_pass++;
      $display("%s: ok", name);
    end else begin
      n_fail++;
      $display("%s: %0d errors", name, errors - base);
    end
  endtask

  task automatic test_arith();
    word_t    ca[4];
    word_t    cb[4];
    alu_req_t r;
    int       base;
    base = errors;
    cb = '{64'h0, 64'h1, 64'h1, 64'h1};
    for (int op = 0; op < 2; op++) begin
      for (int w = 0; w < 2; w++) begin
        if (w == 1) begin
          ca = '{64'h0, 64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000};
        end else begin
          ca = '{64'h0, 64'hffff_ffff, 64'h7fff_ffff, 64'h8000_0000};
        end
        for (int i = 0; i < 4 + RAND_N; i++) begin
          r = build_req(op == 1 ? op_sub : op_add, w == 1, rand_word(), rand_word());
          if (i < 4) begin
            r.a = ca[i];
            r.b = cb[i];
          end
          issue(1'b1, r, 1'b0, 1'b0);
        end
      end
    end
    finish_test("add/sub", base);
  endtask

  task automatic test_logic();
    alu_op_t  ops[3] = '{op_and, op_or, op_xor};
    alu_req_t r;
    int       base;
    base = errors;
    foreach (ops[k]) begin
      for (int i = 0; i < 2 * RAND_N; i++) begin
        r = build_req(ops[k], i[0], rand_word(), rand_word());
        if (i < 2) begin
          r.b = ~r.a;   // zero result for and
        end
        issue(1'b1, r, 1'b0, 1'b0);
      end
    end
    finish_test("and/or/xor", base);
  endtask

  task automatic test_moves();
    alu_op_t     ops[7] = '{op_mov, op_mov, op_zxt8, op_zxt16, op_sxt8, op_sxt16, op_sxt32};
    alu_req_t    r;
    logic [31:0] rv;
    logic        w;
    int          base;
    base = errors;
    foreach (ops[k]) begin
      for (int i = 0; i < RAND_N; i++) begin
        rv = $urandom;
        w = (k == 0) ? 1'b1 : ((k == 1) ? 1'b0 : rv[0]);
        r = build_req(ops[k], w, rand_word(), rand_word());
        r.set_flags = rv[1];
        issue(1'b1, r, 1'b0, 1'b0);
      end
    end
    finish_test("mov/extend", base);
  endtask

  task automatic test_cond();
    alu_req_t    r;
    logic [31:0] rv;
    int          base;
    base = errors;
    for (int k = 0; k < 32; k++) begin
      for (int i = 0; i < COND_REP; i++) begin
        rv = $urandom;
        r = build_req(k < 16 ? op_cmov : op_cset, rv[8], rand_word(), rand_word());
        r.cond.code = cond_code_t'(k[3:1]);
        r.cond.invert = k[0];
        r.flags_in = rv[5:0];
        r.set_flags = rv[6];
        issue(1'b1, r, 1'b0, 1'b0);
      end
    end
    finish_test("cmov/cset", base);
  endtask

  task automatic test_squash();
    alu_req_t r;
    logic     ex;
    int       base;
    base = errors;
    for (int i = 0; i < SQ_N; i++) begin
      r = build_req(op_add, 1'b1, rand_word(), rand_word());
      r.thread = i[1];   // two ops per thread in a row
      ex = (i == 2) || (i == 5) || (i == 8) || (i == 13);
      issue(1'b1, r, ex, (i == 2) || (i == 5));
    end
    finish_test("thread squash", base);
  endtask

  a_valid_match: assert property (@(posedge clk) disable iff (rst)
    expd.chk |-> ret_valid == expd.valid)
    else begin
      errors++;
      $display("ERR %0t: ret_valid %0b, expected %0b", $time, $sampled(ret_valid),
               $sampled(expd.valid));
    end

  a_result_match: assert property (@(posedge clk) disable iff (rst)
    expd.chk && expd.valid |-> resp.result == expd.resp.result)
    else begin
      errors++;
      $display("ERR %0t: result %h, expected %h", $time, $sampled(resp.result),
               $sampled(expd.resp.result));
    end

  a_flags_match: assert property (@(posedge clk) disable iff (rst)
    expd.chk && expd.valid |-> resp.flags == expd.resp.flags
                               && resp.sets_flags == expd.resp.sets_flags)
    else begin
      errors++;
      $display("ERR %0t: flags %b set %0b, expected %b set %0b", $time, $sampled(resp.flags),
               $sampled(resp.sets_flags), $sampled(expd.resp.flags),
               $sampled(expd.resp.sets_flags));
    end

  a_reset_quiet: assert property (@(posedge clk) rst |=> !ret_valid && resp == '0)
    else begin
      errors++;
      $display("ERR %0t: output not cleared by reset", $time);
    end

  initial begin
    int base;
    void'($urandom(SEED));
    valid = 1'b0;
    req = '0;
    except = 1'b0;
    except_thread = 1'b0;
    expd = '0;
    prev_ex = 1'b0;
    prev_ext = 1'b0;
    rst_phase = 1'b1;
    errors = 0;
    n_pass = 0;
    n_fail = 0;
    pending.push_back('0);
    base = errors;
    // a live request that the register stage must drop under reset
    issue(1'b1, build_req(op_or, 1'b1, rand_word(), rand_word()), 1'b0, 1'b0);
    rst_phase = 1'b0;
    issue(1'b0, '0, 1'b0, 1'b0);
    finish_test("reset", base);
    test_arith();
    test_logic();
    test_moves();
    test_cond();
    test_squash();
    $display("tests: %0d passed, %0d failed, %0d check errors", n_pass, n_fail, errors);
    if (errors == 0 && n_fail == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // watchdog
  initial begin
    #((N_OPS + 20) * 100);
    $display("watchdog expired, the run did not reach its end");
    $display("Test failures found");
    $finish;
  end

endmodule

//--- alu_top.f
design/alu_pkg.sv
design/alu_decode.sv
design/alu_adder.sv
design/alu_cond_eval.sv
design/alu_result_mux.sv
design/alu_retire.sv
design/alu_top.sv
bench/alu_clock.sv
bench/alu_tb.sv
